//--- verilog/rv_config.sv
/*
 * Core configuration constants
 * Data width, reset PC and register file geometry
 */

package rv_config;

  //----------------------------------------------------------------------
  // Data path geometry
  //----------------------------------------------------------------------

  // One machine word
  localparam int unsigned xlen = 32;

  // Fetch starts here after reset
  localparam logic [xlen-1:0] initial_pc = 32'h0000_0000;

  //----------------------------------------------------------------------
  // Register file
  //----------------------------------------------------------------------

  localparam int unsigned reg_count = 32;
  localparam int unsigned reg_addr_width = 5;

endpackage

//--- verilog/rv_isa_pkg.sv
/*
 * RV32I encodings shared by control and data path
 * Opcodes, ALU functions, next-PC and writeback selects, funct3 codes
 */

package rv_isa_pkg;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011
  } opcode_e;

  // ALU functions; the last four only serve branch compares
  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_sll  = 5'd2,
    alu_slt  = 5'd3,
    alu_sltu = 5'd4,
    alu_xor  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_or   = 5'd8,
    alu_and  = 5'd9,
    alu_seq  = 5'd10,
    alu_sne  = 5'd11,
    alu_sge  = 5'd12,
    alu_sgeu = 5'd13
  } alu_function_e;

  typedef enum logic [1:0] {
    pc_plus_4   = 2'd0,
    pc_plus_imm = 2'd1,
    pc_alu      = 2'd2
  } next_pc_e;

  typedef enum logic [2:0] {
    wb_alu       = 3'd0,
    wb_mem       = 3'd1,
    wb_pc_plus_4 = 3'd2,
    wb_imm       = 3'd3
  } writeback_e;

  //----------------------------------------------------------------------
  // funct3 codes for branches and word memory access
  //----------------------------------------------------------------------

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;
  localparam logic [2:0] f3_lw   = 3'b010;
  localparam logic [2:0] f3_sw   = 3'b010;

endpackage

//--- verilog/alu.sv
/*
 * 32-bit combinational ALU
 * Arithmetic, logic, shifts and branch compares
 */

module alu (
  input  rv_isa_pkg::alu_function_e alu_function,
  input  logic [31:0]               operand_a,
  input  logic [31:0]               operand_b,
  output logic [31:0]               result
);

  import rv_isa_pkg::*;

  logic [4:0] shamt;

  // Shift amount is always the low five bits
  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_function)
      alu_add:  result = operand_a + operand_b;
      alu_sub:  result = operand_a - operand_b;
      alu_sll:  result = operand_a << shamt;
      alu_srl:  result = operand_a >> shamt;
      alu_sra:  result = $signed(operand_a) >>> shamt;
      alu_xor:  result = operand_a ^ operand_b;
      alu_or:   result = operand_a | operand_b;
      alu_and:  result = operand_a & operand_b;
      // Compares leave a flag in bit 0
      alu_slt:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
      alu_sltu: result = {31'b0, operand_a < operand_b};
      alu_seq:  result = {31'b0, operand_a == operand_b};
      alu_sne:  result = {31'b0, operand_a != operand_b};
      alu_sge:  result = {31'b0, $signed(operand_a) >= $signed(operand_b)};
      alu_sgeu: result = {31'b0, operand_a >= operand_b};
      default:  result = '0;
    endcase
  end

  // Control must never hand over an encoding outside the enum
  always_comb begin
    assert final (alu_function inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                       alu_xor, alu_srl, alu_sra, alu_or, alu_and,
                                       alu_seq, alu_sne, alu_sge, alu_sgeu})
      else $error("alu: unknown function %0d", alu_function);
  end

endmodule

//--- verilog/regfile.sv
/*
 * Integer register file, two read ports and one write port
 * x0 reads as zero and ignores writes
 */

module regfile (
  input  logic                                clock,
  input  logic [rv_config::reg_addr_width-1:0] rs1_address,
  input  logic [rv_config::reg_addr_width-1:0] rs2_address,
  input  logic                                write_enable,
  input  logic [rv_config::reg_addr_width-1:0] rd_address,
  input  logic [rv_config::xlen-1:0]           rd_data,
  output logic [rv_config::xlen-1:0]           rs1_data,
  output logic [rv_config::xlen-1:0]           rs2_data
);

  import rv_config::*;

  // No storage behind x0
  logic [xlen-1:0] registers [1:reg_count-1];

  always_ff @(posedge clock) begin
    if (write_enable && (rd_address != '0)) begin
      registers[rd_address] <= rd_data;
    end
  end

  assign rs1_data = (rs1_address == '0) ? '0 : registers[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : registers[rs2_address];

endmodule

//--- verilog/immediate_generator.sv
/*
 * Immediate decode for the I, S, B, U and J formats
 */

module immediate_generator (
  input  logic [rv_config::xlen-1:0] inst,
  output logic [rv_config::xlen-1:0] immediate
);

  import rv_config::*;

  always_comb begin
    case (inst[6:0])
      // I type: op-imm, load, jalr
      7'b0010011, 7'b0000011, 7'b1100111:
        immediate = {{(xlen-12){inst[31]}}, inst[31:20]};
      // S type
      7'b0100011:
        immediate = {{(xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
      // B type, halfword offset
      7'b1100011:
        immediate = {{(xlen-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                     inst[11:8], 1'b0};
      // U type: lui, auipc
      7'b0110111, 7'b0010111:
        immediate = {inst[31:12], 12'b0};
      // J type
      7'b1101111:
        immediate = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                     inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

//--- verilog/singlecycle_datapath.sv
/*
 * Single-cycle data path
 * PC register, field split, operand and writeback muxes, next-PC logic
 */

module singlecycle_datapath (
  input  logic                      clock,
  input  logic [rv_config::xlen-1:0] inst,
  input  rv_isa_pkg::alu_function_e alu_function,
  input  logic                      alu_operand_a_select,
  input  logic                      alu_operand_b_select,
  input  logic                      reset,
  input  logic                      regfile_write_enable,
  input  logic [rv_config::xlen-1:0] data_mem_read_data,
  input  rv_isa_pkg::writeback_e    reg_writeback_select,
  input  rv_isa_pkg::next_pc_e      next_pc_select,
  input  logic                      pc_write_enable,
  output logic [rv_config::xlen-1:0] pc,
  output logic [rv_config::xlen-1:0] rs2_data,
  output rv_isa_pkg::opcode_e       inst_opcode,
  output logic [2:0]                inst_funct3,
  output logic [6:0]                inst_funct7,
  output logic [rv_config::xlen-1:0] alu_result
);

  import rv_config::*;
  import rv_isa_pkg::*;

  logic [reg_addr_width-1:0] rd_idx;
  logic [reg_addr_width-1:0] rs1_idx;
  logic [reg_addr_width-1:0] rs2_idx;
  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           immediate;
  logic [xlen-1:0]           operand_a;
  logic [xlen-1:0]           operand_b;
  logic [xlen-1:0]           pc_plus_4_value;
  logic [xlen-1:0]           pc_plus_imm_value;
  logic [xlen-1:0]           pc_next;
  logic [xlen-1:0]           rd_data;

  //----------------------------------------------------------------------
  // Instruction fields
  //----------------------------------------------------------------------

  assign inst_opcode = opcode_e'(inst[6:0]);
  assign rd_idx      = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign rs1_idx     = inst[19:15];
  assign rs2_idx     = inst[24:20];
  assign inst_funct7 = inst[31:25];

  //----------------------------------------------------------------------
  // Execute
  //----------------------------------------------------------------------

  // a: rs1 or PC, b: rs2 or immediate
  assign operand_a = alu_operand_a_select ? pc : rs1_data;
  assign operand_b = alu_operand_b_select ? immediate : rs2_data;

  // Dedicated adders, the ALU stays free for branch compares
  assign pc_plus_4_value   = pc + 32'd4;
  assign pc_plus_imm_value = pc + immediate;

  always_comb begin
    case (next_pc_select)
      pc_plus_imm: pc_next = pc_plus_imm_value;
      pc_alu:      pc_next = {alu_result[xlen-1:1], 1'b0};
      default:     pc_next = pc_plus_4_value;
    endcase
  end

  always_comb begin
    case (reg_writeback_select)
      wb_mem:       rd_data = data_mem_read_data;
      wb_pc_plus_4: rd_data = pc_plus_4_value;
      wb_imm:       rd_data = immediate;
      default:      rd_data = alu_result;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= initial_pc;
    end else if (pc_write_enable) begin
      pc <= pc_next;
    end
  end

  alu alu_core (
    .alu_function (alu_function),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .result       (alu_result)
  );

  regfile regs (
    .clock        (clock),
    .rs1_address  (rs1_idx),
    .rs2_address  (rs2_idx),
    .write_enable (regfile_write_enable),
    .rd_address   (rd_idx),
    .rd_data      (rd_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  immediate_generator igen (
    .inst      (inst),
    .immediate (immediate)
  );

  // Misaligned jump targets are not trapped, so catch them here
  pc_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- verilog/singlecycle_control.sv
/*
 * Single-cycle control
 * Opcode and funct decode, branch resolution from the ALU compare
 */

module singlecycle_control (
  input  rv_isa_pkg::opcode_e        inst_opcode,
  input  logic [2:0]                 inst_funct3,
  input  logic [6:0]                 inst_funct7,
  input  logic [rv_config::xlen-1:0] alu_result,
  output rv_isa_pkg::alu_function_e  alu_function,
  output logic                       alu_operand_a_select,
  output logic                       alu_operand_b_select,
  output logic                       regfile_write_enable,
  output rv_isa_pkg::writeback_e     reg_writeback_select,
  output rv_isa_pkg::next_pc_e       next_pc_select,
  output logic                       data_write_enable
);

  import rv_isa_pkg::*;

  logic     is_branch;
  next_pc_e decoded_next_pc;

  // alt picks sub over add and sra over srl
  function automatic alu_function_e arith_function(input logic [2:0] funct3,
                                                   input logic alt);
    case (funct3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_function_e branch_function(input logic [2:0] funct3);
    case (funct3)
      f3_beq:  return alu_seq;
      f3_bne:  return alu_sne;
      f3_blt:  return alu_slt;
      f3_bge:  return alu_sge;
      f3_bltu: return alu_sltu;
      default: return alu_sgeu;
    endcase
  endfunction

  //----------------------------------------------------------------------
  // Main decode
  //----------------------------------------------------------------------

  always_comb begin
    // Anything not matched below retires as a NOP
    alu_function         = alu_add;
    alu_operand_a_select = 1'b0;
    alu_operand_b_select = 1'b0;
    regfile_write_enable = 1'b0;
    reg_writeback_select = wb_alu;
    decoded_next_pc      = pc_plus_4;
    data_write_enable    = 1'b0;
    is_branch            = 1'b0;

    case (inst_opcode)
      op_lui: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = wb_imm;
      end
      op_auipc: begin
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      op_jal: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = wb_pc_plus_4;
        decoded_next_pc      = pc_plus_imm;
      end
      op_jalr: begin
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
        reg_writeback_select = wb_pc_plus_4;
        decoded_next_pc      = pc_alu;
      end
      op_branch: begin
        if (inst_funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
          alu_function = branch_function(inst_funct3);
          is_branch    = 1'b1;
        end
      end
      op_load: begin
        if (inst_funct3 == f3_lw) begin
          alu_operand_b_select = 1'b1;
          regfile_write_enable = 1'b1;
          reg_writeback_select = wb_mem;
        end
      end
      op_store: begin
        if (inst_funct3 == f3_sw) begin
          alu_operand_b_select = 1'b1;
          data_write_enable    = 1'b1;
        end
      end
      op_imm: begin
        // Only srai carries the alt bit since addi has no subtract form
        alu_function = arith_function(inst_funct3,
                                      (inst_funct3 == 3'b101) && inst_funct7[5]);
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      op_reg: begin
        alu_function         = arith_function(inst_funct3, inst_funct7[5]);
        regfile_write_enable = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Compare flag lands in bit 0 of the ALU result
  assign next_pc_select = (is_branch && alu_result[0]) ? pc_plus_imm : decoded_next_pc;

endmodule

//--- verilog/rv_core_top.sv
/*
 * Single-cycle RV32I core top level
 * Control plus data path, fetch and data memory ports
 */

module rv_core_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [rv_config::xlen-1:0] inst,
  output logic [rv_config::xlen-1:0] pc,
  output logic [rv_config::xlen-1:0] data_address,
  output logic [rv_config::xlen-1:0] data_write_data,
  output logic                       data_write_enable,
  input  logic [rv_config::xlen-1:0] data_read_data
);

  import rv_config::*;
  import rv_isa_pkg::*;

  opcode_e         inst_opcode;
  logic [2:0]      inst_funct3;
  logic [6:0]      inst_funct7;
  logic [xlen-1:0] alu_result;
  alu_function_e   alu_function;
  logic            alu_operand_a_select;
  logic            alu_operand_b_select;
  logic            regfile_write_enable;
  writeback_e      reg_writeback_select;
  next_pc_e        next_pc_select;

  // Loads and stores address memory straight from the ALU
  assign data_address = alu_result;

  singlecycle_datapath datapath (
    .clock                (clock),
    .inst                 (inst),
    .alu_function         (alu_function),
    .alu_operand_a_select (alu_operand_a_select),
    .alu_operand_b_select (alu_operand_b_select),
    .reset                (reset),
    .regfile_write_enable (regfile_write_enable),
    .data_mem_read_data   (data_read_data),
    .reg_writeback_select (reg_writeback_select),
    .next_pc_select       (next_pc_select),
    .pc_write_enable      (1'b1),
    .pc                   (pc),
    .rs2_data             (data_write_data),
    .inst_opcode          (inst_opcode),
    .inst_funct3          (inst_funct3),
    .inst_funct7          (inst_funct7),
    .alu_result           (alu_result)
  );

  singlecycle_control control (
    .inst_opcode          (inst_opcode),
    .inst_funct3          (inst_funct3),
    .inst_funct7          (inst_funct7),
    .alu_result           (alu_result),
    .alu_function         (alu_function),
    .alu_operand_a_select (alu_operand_a_select),
    .alu_operand_b_select (alu_operand_b_select),
    .regfile_write_enable (regfile_write_enable),
    .reg_writeback_select (reg_writeback_select),
    .next_pc_select       (next_pc_select),
    .data_write_enable    (data_write_enable)
  );

endmodule

//--- dv/tb_rv_programs.svh
/*
 * Test program for the single-cycle core, one row per cycle
 * Each row gives the instruction, the pc before the edge and, for stores,
 * the expected data address and write data
 */

`ifndef TB_RV_PROGRAMS_SVH
`define TB_RV_PROGRAMS_SVH

task automatic build_table();
  // x1 = -1, x2 = 5, x3 = 0x8000_0000, then results stored word by word
  add_step ("addi_m1",   i_format(-1, 0, 0, 1, op_imm),       32'd0);
  add_step ("addi_5",    i_format(5, 0, 0, 2, op_imm),        32'd4);
  add_step ("lui",       u_format(32'h80000, 3, op_lui),      32'd8);
  add_store("sw_lui",    s_format(0, 3, 0),   32'd12, 32'd0,  32'h8000_0000);
  add_step ("sub",       r_format(32, 1, 2, 0, 4),            32'd16);
  add_store("sw_sub",    s_format(4, 4, 0),   32'd20, 32'd4,  32'h0000_0006);
  add_step ("sra",       r_format(32, 2, 3, 5, 5),            32'd24);
  add_store("sw_sra",    s_format(8, 5, 0),   32'd28, 32'd8,  32'hfc00_0000);
  add_step ("srli",      i_format(4, 3, 5, 6, op_imm),        32'd32);
  add_store("sw_srli",   s_format(12, 6, 0),  32'd36, 32'd12, 32'h0800_0000);
  add_step ("slt",       r_format(0, 2, 1, 2, 7),             32'd40);
  add_store("sw_slt",    s_format(16, 7, 0),  32'd44, 32'd16, 32'h0000_0001);
  add_step ("sltu",      r_format(0, 2, 1, 3, 8),             32'd48);
  add_store("sw_sltu",   s_format(20, 8, 0),  32'd52, 32'd20, 32'h0000_0000);
  add_step ("andi",      i_format(32'h5a5, 1, 7, 9, op_imm),  32'd56);
  add_store("sw_andi",   s_format(24, 9, 0),  32'd60, 32'd24, 32'h0000_05a5);

  // Write to x0 must be dropped
  add_step ("addi_x0",   i_format(7, 2, 0, 0, op_imm),        32'd64);
  add_store("sw_x0",     s_format(28, 0, 0),  32'd68, 32'd28, 32'h0000_0000);

  // Word stored by sw_sub comes back through a load
  add_step ("lw",        i_format(4, 0, 2, 10, op_load),      32'd72);
  add_store("sw_lw",     s_format(32, 10, 0), 32'd76, 32'd32, 32'h0000_0006);
  add_step ("auipc",     u_format(1, 11, op_auipc),           32'd80);
  add_store("sw_auipc",  s_format(36, 11, 0), 32'd84, 32'd36, 32'h0000_1050);

  // Branches, taken then not taken for each kind
  add_step ("beq_t",     b_format(8, 2, 2, f3_beq),           32'd88);
  add_step ("beq_nt",    b_format(8, 4, 2, f3_beq),           32'd96);
  add_step ("bne_t",     b_format(12, 4, 2, f3_bne),          32'd100);
  add_step ("bne_nt",    b_format(8, 2, 2, f3_bne),           32'd112);
  add_step ("blt_t",     b_format(8, 2, 1, f3_blt),           32'd116);
  add_step ("blt_nt",    b_format(8, 1, 2, f3_blt),           32'd124);
  add_step ("bge_t",     b_format(8, 1, 2, f3_bge),           32'd128);
  add_step ("bge_nt",    b_format(8, 2, 1, f3_bge),           32'd136);
  add_step ("bltu_t",    b_format(8, 1, 2, f3_bltu),          32'd140);
  add_step ("bltu_nt",   b_format(8, 2, 1, f3_bltu),          32'd148);
  add_step ("bgeu_t",    b_format(8, 2, 1, f3_bgeu),          32'd152);
  add_step ("bgeu_nt",   b_format(8, 4, 2, f3_bgeu),          32'd160);
  add_step ("beq_back",  b_format(-8, 0, 0, f3_beq),          32'd164);

  // Jumps, link values stored afterwards
  add_step ("jal",       j_format(20, 12),                    32'd156);
  add_store("sw_jal",    s_format(40, 12, 0), 32'd176, 32'd40, 32'h0000_00a0);
  // x2 + 12 = 17, bit 0 cleared gives 16
  add_step ("jalr",      i_format(12, 2, 0, 13, op_jalr),     32'd180);
  add_store("sw_jalr",   s_format(44, 13, 0), 32'd16,  32'd44, 32'h0000_00b8);
  add_store("sw_after",  s_format(48, 5, 0),  32'd20,  32'd48, 32'hfc00_0000);
endtask

`endif

//--- dv/tb_rv_core.sv
/*
 * Testbench for the single-cycle RV32I core
 * Clock, reset, data memory model, instruction encoders, table loop,
 * checks and timeout
 */

module tb_rv_core;

  import rv_isa_pkg::*;

  localparam int reset_cycles = 4;
  localparam int mem_words = 16;

  // addi x0, x0, 0
  localparam logic [31:0] nop_word = 32'h0000_0013;

  logic        clock = 1'b0;
  logic        reset;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] data_address;
  logic [31:0] data_write_data;
  logic        data_write_enable;
  logic [31:0] data_read_data;

  logic [31:0] data_mem [0:mem_words-1];

  // Test table, one entry per instruction
  string       name_q[$];
  logic [31:0] inst_q[$];
  logic [31:0] pc_q[$];
  logic        we_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] wdata_q[$];

  int error_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  always #4 clock = ~clock;

  rv_core_top i_dut (
    .clock             (clock),
    .reset             (reset),
    .inst              (inst),
    .pc                (pc),
    .data_address      (data_address),
    .data_write_data   (data_write_data),
    .data_write_enable (data_write_enable),
    .data_read_data    (data_read_data)
  );

  //----------------------------------------------------------------------
  // Data memory model, word addressed
  //----------------------------------------------------------------------

  assign data_read_data = data_mem[data_address[5:2]];

  always @(posedge clock) begin
    if (!reset && data_write_enable) begin
      data_mem[data_address[5:2]] <= data_write_data;
    end
  end

  //----------------------------------------------------------------------
  // Instruction encoders, arguments in bit-field order
  //----------------------------------------------------------------------

  function automatic logic [31:0] r_format(input int funct7, input int rs2, input int rs1,
                                           input int funct3, input int rd);
    return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_format(input int imm, input int rs1, input int funct3,
                                           input int rd, input logic [6:0] opcode);
    logic [31:0] v;
    v = imm;
    return {v[11:0], 5'(rs1), 3'(funct3), 5'(rd), opcode};
  endfunction

  function automatic logic [31:0] s_format(input int imm, input int rs2, input int rs1);
    logic [31:0] v;
    v = imm;
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_format(input int imm, input int rs2, input int rs1,
                                           input int funct3);
    logic [31:0] v;
    v = imm;
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(funct3), v[4:1], v[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_format(input int imm20, input int rd,
                                           input logic [6:0] opcode);
    logic [31:0] v;
    v = imm20;
    return {v[19:0], 5'(rd), opcode};
  endfunction

  function automatic logic [31:0] j_format(input int imm, input int rd);
    logic [31:0] v;
    v = imm;
    return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
  endfunction

  // Row without a memory write
  task automatic add_step(input string name, input logic [31:0] word,
                          input logic [31:0] exp_pc);
    name_q.push_back(name);
    inst_q.push_back(word);
    pc_q.push_back(exp_pc);
    we_q.push_back(1'b0);
    addr_q.push_back(32'h0);
    wdata_q.push_back(32'h0);
  endtask

  task automatic add_store(input string name, input logic [31:0] word,
                           input logic [31:0] exp_pc, input logic [31:0] exp_addr,
                           input logic [31:0] exp_wdata);
    name_q.push_back(name);
    inst_q.push_back(word);
    pc_q.push_back(exp_pc);
    we_q.push_back(1'b1);
    addr_q.push_back(exp_addr);
    wdata_q.push_back(exp_wdata);
  endtask

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, field, expected, actual);
      error_count++;
    end
  endtask

  `include "tb_rv_programs.svh"

  //----------------------------------------------------------------------
  // Timeout
  //----------------------------------------------------------------------

  always @(posedge clock) begin
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not end within %0d clock cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------

  initial begin
    int errors_before;

    reset = 1'b1;
    inst  = nop_word;
    for (int a = 0; a < mem_words; a++) begin
      data_mem[a] = {16'hd0d0, 16'(a * 4)};
    end
    build_table();
    cycle_limit = inst_q.size() + reset_cycles + 20;

    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int i = 0; i < inst_q.size(); i++) begin
      inst = inst_q[i];
      errors_before = error_count;
      // Outputs are settled by the falling edge
      @(negedge clock);
      check_value(name_q[i], "pc", pc_q[i], pc);
      check_value(name_q[i], "data_write_enable", {31'b0, we_q[i]},
                  {31'b0, data_write_enable});
      if (we_q[i]) begin
        check_value(name_q[i], "data_address", addr_q[i], data_address);
        check_value(name_q[i], "data_write_data", wdata_q[i], data_write_data);
      end
      if (error_count == errors_before) begin
        pass_count++;
        $display("%-14s pc %h  ok", name_q[i], pc);
      end else begin
        fail_count++;
        $display("%-14s pc %h  mismatch", name_q[i], pc);
      end
      @(posedge clock);
      #1;
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", inst_q.size(), pass_count,
             fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+dv
verilog/rv_config.sv
verilog/rv_isa_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/immediate_generator.sv
verilog/singlecycle_datapath.sv
verilog/singlecycle_control.sv
verilog/rv_core_top.sv
dv/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - verilog/rv_config.sv
      - verilog/rv_isa_pkg.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - verilog/immediate_generator.sv
      - verilog/singlecycle_datapath.sv
      - verilog/singlecycle_control.sv
      - verilog/rv_core_top.sv

  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_rv_core.sv
